//--- include/hash_table_params.svh
`ifndef HASH_TABLE_PARAMS_SVH
`define HASH_TABLE_PARAMS_SVH

// key and value payload widths
`define HT_KEY_WIDTH    16
`define HT_VALUE_WIDTH  16

// entry RAM address width, 16 entries
`define HT_ADDR_WIDTH   4

// bucket index width, 8 buckets in the head table
`define HT_BUCKET_WIDTH 3

`endif

//--- hdl/hash_table_pkg.sv
`include "hash_table_params.svh"

package hash_table_pkg;

  // host opcodes
  typedef enum logic [1:0] {
    OP_INSERT = 2'd0,
    OP_SEARCH = 2'd1,
    OP_CLEAR  = 2'd2
  } ht_opcode_e;

  // result codes returned with the acknowledge
  typedef enum logic [2:0] {
    ST_INSERTED   = 3'd0,
    ST_TABLE_FULL = 3'd1,
    ST_FOUND      = 3'd2,
    ST_NOT_FOUND  = 3'd3,
    ST_CLEARED    = 3'd4
  } ht_status_e;

  // host command, held stable while cmd_req_i is high
  typedef struct packed {
    ht_opcode_e                 opcode;
    logic [`HT_KEY_WIDTH-1:0]   key;
    logic [`HT_VALUE_WIDTH-1:0] value;
  } ht_cmd_t;

  // host result, value only meaningful for ST_FOUND
  typedef struct packed {
    ht_status_e                 status;
    logic [`HT_VALUE_WIDTH-1:0] value;
  } ht_res_t;

  // one chain link in the entry RAM
  typedef struct packed {
    logic [`HT_KEY_WIDTH-1:0]   key;
    logic [`HT_VALUE_WIDTH-1:0] value;
    logic [`HT_ADDR_WIDTH-1:0]  next_ptr;
    logic                       next_ptr_val;
  } ram_data_t;

  // memory request from one engine to the arbiter
  typedef struct packed {
    logic                       req;
    logic                       we;
    logic [`HT_ADDR_WIDTH-1:0]  addr;
    ram_data_t                  wdata;
  } mem_req_t;

endpackage

//--- hdl/entry_ram.sv
`timescale 1ns/100ps

`include "hash_table_params.svh"

module entry_ram (
  input  logic                      clk_i,
  input  logic                      en_i,
  input  logic                      we_i,
  input  logic [`HT_ADDR_WIDTH-1:0] addr_i,
  input  hash_table_pkg::ram_data_t wdata_i,
  output hash_table_pkg::ram_data_t rdata_o
);

  // one word per entry address
  hash_table_pkg::ram_data_t mem [2**`HT_ADDR_WIDTH];

  // single port, write or read in a cycle
  // read data lands on rdata_o one cycle after the address
  always_ff @(posedge clk_i)
  begin
    if (en_i)
    begin
      if (we_i)
        mem[addr_i] <= wdata_i;
      else
        rdata_o <= mem[addr_i];
    end
  end

endmodule

//--- hdl/entry_ram_arbiter.sv
`timescale 1ns/100ps

`include "hash_table_params.svh"

module entry_ram_arbiter (
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  hash_table_pkg::mem_req_t  clr_req_i,
  input  hash_table_pkg::mem_req_t  ins_req_i,
  input  hash_table_pkg::mem_req_t  srch_req_i,
  output logic                      clr_gnt_o,
  output logic                      ins_gnt_o,
  output logic                      srch_gnt_o,
  output logic                      ram_en_o,
  output logic                      ram_we_o,
  output logic [`HT_ADDR_WIDTH-1:0] ram_addr_o,
  output hash_table_pkg::ram_data_t ram_wdata_o
);

  // outstanding read per master, {search, insert, clear}
  logic [2:0]               rd_pend_q;
  logic                     rd_busy;
  hash_table_pkg::mem_req_t sel_req;

  assign rd_busy = |rd_pend_q;

  // fixed priority: clear, then insert, then search
  // no grant at all while a read is still returning
  always_comb
  begin
    clr_gnt_o  = 1'b0;
    ins_gnt_o  = 1'b0;
    srch_gnt_o = 1'b0;
    if (!rd_busy)
    begin
      if (clr_req_i.req)
        clr_gnt_o = 1'b1;
      else if (ins_req_i.req)
        ins_gnt_o = 1'b1;
      else if (srch_req_i.req)
        srch_gnt_o = 1'b1;
    end
  end

  // forward the winner to the RAM, idle request otherwise
  always_comb
  begin
    sel_req = '0;
    if (clr_gnt_o)
      sel_req = clr_req_i;
    else if (ins_gnt_o)
      sel_req = ins_req_i;
    else if (srch_gnt_o)
      sel_req = srch_req_i;
  end

  assign ram_en_o    = sel_req.req;
  assign ram_we_o    = sel_req.we;
  assign ram_addr_o  = sel_req.addr;
  assign ram_wdata_o = sel_req.wdata;

  // a granted read is pending for exactly one cycle
  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
      rd_pend_q <= 3'b000;
    else
      rd_pend_q <= {srch_gnt_o & ~srch_req_i.we,
                    ins_gnt_o & ~ins_req_i.we,
                    clr_gnt_o & ~clr_req_i.we};
  end

endmodule

//--- hdl/table_clear_engine.sv
`timescale 1ns/100ps

`include "hash_table_params.svh"

module table_clear_engine (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  logic                     start_i,
  input  logic                     gnt_i,
  output hash_table_pkg::mem_req_t mem_o,
  output logic                     done_o
);

  // high while the sweep runs
  logic                      run_q;
  logic [`HT_ADDR_WIDTH-1:0] addr_q;

  // zero entry at the current sweep address
  always_comb
  begin
    mem_o      = '0;
    mem_o.req  = run_q;
    mem_o.we   = 1'b1;
    mem_o.addr = addr_q;
  end

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      run_q  <= 1'b0;
      addr_q <= '0;
      done_o <= 1'b0;
    end
    else
    begin
      done_o <= 1'b0;
      if (start_i)
      begin
        run_q  <= 1'b1;
        addr_q <= '0;
      end
      else if (run_q && gnt_i)
      begin
        addr_q <= addr_q + 1'b1;
        // last address written, stop and report
        if (addr_q == '1)
        begin
          run_q  <= 1'b0;
          done_o <= 1'b1;
        end
      end
    end
  end

endmodule

//--- hdl/chain_insert_engine.sv
`timescale 1ns/100ps

`include "hash_table_params.svh"

module chain_insert_engine (
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  logic                       start_i,
  input  logic                       reset_alloc_i,
  input  logic [`HT_KEY_WIDTH-1:0]   key_i,
  input  logic [`HT_VALUE_WIDTH-1:0] value_i,
  input  logic [`HT_ADDR_WIDTH-1:0]  head_ptr_i,
  input  logic                       head_val_i,
  input  logic                       gnt_i,
  output hash_table_pkg::mem_req_t   mem_o,
  output logic                       done_o,
  output hash_table_pkg::ht_status_e status_o,
  output logic [`HT_ADDR_WIDTH-1:0]  new_addr_o
);

  // write waiting for its grant
  logic                      busy_q;
  // next free address, entries are never recycled
  logic [`HT_ADDR_WIDTH-1:0] alloc_q;
  // every address handed out since the last clear
  logic                      full_q;
  // new head entry, links to the old head of its chain
  hash_table_pkg::ram_data_t entry_q;

  always_comb
  begin
    mem_o       = '0;
    mem_o.req   = busy_q;
    mem_o.we    = 1'b1;
    mem_o.addr  = alloc_q;
    mem_o.wdata = entry_q;
  end

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      busy_q     <= 1'b0;
      alloc_q    <= '0;
      full_q     <= 1'b0;
      done_o     <= 1'b0;
      status_o   <= hash_table_pkg::ST_INSERTED;
      new_addr_o <= '0;
    end
    else
    begin
      done_o <= 1'b0;
      if (reset_alloc_i)
      begin
        alloc_q <= '0;
        full_q  <= 1'b0;
      end
      else if (start_i)
      begin
        // full table answers at once, RAM untouched
        if (full_q)
        begin
          done_o   <= 1'b1;
          status_o <= hash_table_pkg::ST_TABLE_FULL;
        end
        else
          busy_q <= 1'b1;
      end
      else if (busy_q && gnt_i)
      begin
        busy_q     <= 1'b0;
        done_o     <= 1'b1;
        status_o   <= hash_table_pkg::ST_INSERTED;
        new_addr_o <= alloc_q;
        alloc_q    <= alloc_q + 1'b1;
        // counter wraps on the last address
        if (alloc_q == '1)
          full_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (start_i)
    begin
      entry_q.key          <= key_i;
      entry_q.value        <= value_i;
      entry_q.next_ptr     <= head_ptr_i;
      entry_q.next_ptr_val <= head_val_i;
    end
  end

endmodule

//--- hdl/chain_search_engine.sv
`timescale 1ns/100ps

`include "hash_table_params.svh"

module chain_search_engine (
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  logic                       start_i,
  input  logic [`HT_KEY_WIDTH-1:0]   key_i,
  input  logic [`HT_ADDR_WIDTH-1:0]  head_ptr_i,
  input  logic                       head_val_i,
  input  logic                       gnt_i,
  input  hash_table_pkg::ram_data_t  rd_data_i,
  output hash_table_pkg::mem_req_t   mem_o,
  output logic                       done_o,
  output logic                       found_o,
  output logic [`HT_VALUE_WIDTH-1:0] value_o
);

  // REQ holds the read request, WAIT takes the data, CHECK compares
  typedef enum logic [1:0] {
    IDLE,
    REQ,
    WAIT,
    CHECK
  } state_e;

  state_e                    state_q;
  logic [`HT_KEY_WIDTH-1:0]  key_q;
  // address of the link being fetched
  logic [`HT_ADDR_WIDTH-1:0] ptr_q;
  // captured link, rd_data_i is only valid for one cycle
  hash_table_pkg::ram_data_t link_q;

  // read of the current link
  always_comb
  begin
    mem_o      = '0;
    mem_o.req  = (state_q == REQ);
    mem_o.addr = ptr_q;
  end

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      state_q <= IDLE;
      done_o  <= 1'b0;
      found_o <= 1'b0;
    end
    else
    begin
      done_o <= 1'b0;
      case (state_q)
        IDLE:
        begin
          if (start_i)
          begin
            // empty bucket ends the search without a read
            if (head_val_i)
              state_q <= REQ;
            else
            begin
              done_o  <= 1'b1;
              found_o <= 1'b0;
            end
          end
        end
        REQ:
        begin
          if (gnt_i)
            state_q <= WAIT;
        end
        WAIT:
        begin
          state_q <= CHECK;
        end
        CHECK:
        begin
          // first match is the newest value for this key
          if (link_q.key == key_q)
          begin
            state_q <= IDLE;
            done_o  <= 1'b1;
            found_o <= 1'b1;
          end
          else if (link_q.next_ptr_val)
            state_q <= REQ;
          else
          begin
            state_q <= IDLE;
            done_o  <= 1'b1;
            found_o <= 1'b0;
          end
        end
        default:
        begin
          state_q <= IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (state_q == IDLE && start_i)
    begin
      key_q <= key_i;
      ptr_q <= head_ptr_i;
    end
    if (state_q == WAIT)
      link_q <= rd_data_i;
    // follow the chain, value kept for a hit
    if (state_q == CHECK)
    begin
      ptr_q   <= link_q.next_ptr;
      value_o <= link_q.value;
    end
  end

endmodule

//--- hdl/hash_cmd_ctrl.sv
`timescale 1ns/100ps

`include "hash_table_params.svh"

module hash_cmd_ctrl (
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  logic                       cmd_req_i,
  input  hash_table_pkg::ht_cmd_t    cmd_i,
  output logic                       cmd_ack_o,
  output hash_table_pkg::ht_res_t    res_o,
  output logic                       clr_start_o,
  output logic                       ins_start_o,
  output logic                       srch_start_o,
  output logic                       reset_alloc_o,
  output logic [`HT_KEY_WIDTH-1:0]   key_o,
  output logic [`HT_VALUE_WIDTH-1:0] value_o,
  output logic [`HT_ADDR_WIDTH-1:0]  head_ptr_o,
  output logic                       head_val_o,
  input  logic                       clr_done_i,
  input  logic                       ins_done_i,
  input  hash_table_pkg::ht_status_e ins_status_i,
  input  logic [`HT_ADDR_WIDTH-1:0]  ins_addr_i,
  input  logic                       srch_done_i,
  input  logic                       srch_found_i,
  input  logic [`HT_VALUE_WIDTH-1:0] srch_value_i
);

  localparam int NUM_BUCKETS = 2**`HT_BUCKET_WIDTH;

  typedef enum logic [1:0] {
    IDLE,
    BUSY,
    ACK
  } state_e;

  state_e                         state_q;
  hash_table_pkg::ht_cmd_t        cmd_q;
  hash_table_pkg::ht_res_t        res_q;
  logic [`HT_BUCKET_WIDTH-1:0]    bucket_q;
  // head table, pointer per bucket plus its valid bit
  logic [`HT_ADDR_WIDTH-1:0]      head_ptr_q [NUM_BUCKETS];
  logic [NUM_BUCKETS-1:0]         head_val_q;

  // xor fold of the key into a bucket, bit i lands on slot i mod width
  function automatic logic [`HT_BUCKET_WIDTH-1:0] fold_key(
    input logic [`HT_KEY_WIDTH-1:0] key
  );
    logic [`HT_BUCKET_WIDTH-1:0] acc;
    acc = '0;
    for (int i = 0; i < `HT_KEY_WIDTH; i++)
      acc[i % `HT_BUCKET_WIDTH] ^= key[i];
    return acc;
  endfunction

  assign cmd_ack_o  = (state_q == ACK);
  assign res_o      = res_q;
  assign key_o      = cmd_q.key;
  assign value_o    = cmd_q.value;
  // head entry of the registered bucket, stable while an engine runs
  assign head_ptr_o = head_ptr_q[bucket_q];
  assign head_val_o = head_val_q[bucket_q];

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      state_q       <= IDLE;
      clr_start_o   <= 1'b0;
      ins_start_o   <= 1'b0;
      srch_start_o  <= 1'b0;
      reset_alloc_o <= 1'b0;
      head_val_q    <= '0;
    end
    else
    begin
      clr_start_o   <= 1'b0;
      ins_start_o   <= 1'b0;
      srch_start_o  <= 1'b0;
      reset_alloc_o <= 1'b0;
      case (state_q)
        IDLE:
        begin
          if (cmd_req_i)
          begin
            state_q <= BUSY;
            case (cmd_i.opcode)
              hash_table_pkg::OP_INSERT: ins_start_o <= 1'b1;
              hash_table_pkg::OP_SEARCH: srch_start_o <= 1'b1;
              // clear, the unused code also wipes
              default: clr_start_o <= 1'b1;
            endcase
          end
        end
        BUSY:
        begin
          // one engine runs, any done ends the command
          if (clr_done_i || ins_done_i || srch_done_i)
            state_q <= ACK;
          if (clr_done_i)
          begin
            head_val_q    <= '0;
            reset_alloc_o <= 1'b1;
          end
          if (ins_done_i && ins_status_i == hash_table_pkg::ST_INSERTED)
            head_val_q[bucket_q] <= 1'b1;
        end
        ACK:
        begin
          // hold the result until the host lets go
          if (!cmd_req_i)
            state_q <= IDLE;
        end
        default:
        begin
          state_q <= IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (state_q == IDLE && cmd_req_i)
    begin
      cmd_q    <= cmd_i;
      bucket_q <= fold_key(cmd_i.key);
    end
    // new entry becomes the head of its chain
    if (state_q == BUSY && ins_done_i && ins_status_i == hash_table_pkg::ST_INSERTED)
      head_ptr_q[bucket_q] <= ins_addr_i;
    if (state_q == BUSY)
    begin
      if (clr_done_i)
      begin
        res_q.status <= hash_table_pkg::ST_CLEARED;
        res_q.value  <= '0;
      end
      else if (ins_done_i)
      begin
        res_q.status <= ins_status_i;
        res_q.value  <= '0;
      end
      else if (srch_done_i)
      begin
        res_q.status <= srch_found_i ? hash_table_pkg::ST_FOUND
                                     : hash_table_pkg::ST_NOT_FOUND;
        res_q.value  <= srch_found_i ? srch_value_i : '0;
      end
    end
  end

endmodule

//--- hdl/hash_table_top.sv
`timescale 1ns/100ps

`include "hash_table_params.svh"

module hash_table_top (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  logic                    cmd_req_i,
  input  hash_table_pkg::ht_cmd_t cmd_i,
  output logic                    cmd_ack_o,
  output hash_table_pkg::ht_res_t res_o
);

  // controller to engines
  logic                       clr_start;
  logic                       ins_start;
  logic                       srch_start;
  logic                       reset_alloc;
  logic [`HT_KEY_WIDTH-1:0]   key;
  logic [`HT_VALUE_WIDTH-1:0] value;
  logic [`HT_ADDR_WIDTH-1:0]  head_ptr;
  logic                       head_val;

  // engines back to the controller
  logic                       clr_done;
  logic                       ins_done;
  hash_table_pkg::ht_status_e ins_status;
  logic [`HT_ADDR_WIDTH-1:0]  ins_addr;
  logic                       srch_done;
  logic                       srch_found;
  logic [`HT_VALUE_WIDTH-1:0] srch_value;

  // engine memory masters
  hash_table_pkg::mem_req_t   clr_mem;
  hash_table_pkg::mem_req_t   ins_mem;
  hash_table_pkg::mem_req_t   srch_mem;
  logic                       clr_gnt;
  logic                       ins_gnt;
  logic                       srch_gnt;

  // arbitrated RAM port
  logic                       ram_en;
  logic                       ram_we;
  logic [`HT_ADDR_WIDTH-1:0]  ram_addr;
  hash_table_pkg::ram_data_t  ram_wdata;
  hash_table_pkg::ram_data_t  ram_rdata;

  hash_cmd_ctrl u_ctrl (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .cmd_req_i     (cmd_req_i),
    .cmd_i         (cmd_i),
    .cmd_ack_o     (cmd_ack_o),
    .res_o         (res_o),
    .clr_start_o   (clr_start),
    .ins_start_o   (ins_start),
    .srch_start_o  (srch_start),
    .reset_alloc_o (reset_alloc),
    .key_o         (key),
    .value_o       (value),
    .head_ptr_o    (head_ptr),
    .head_val_o    (head_val),
    .clr_done_i    (clr_done),
    .ins_done_i    (ins_done),
    .ins_status_i  (ins_status),
    .ins_addr_i    (ins_addr),
    .srch_done_i   (srch_done),
    .srch_found_i  (srch_found),
    .srch_value_i  (srch_value)
  );

  table_clear_engine u_clear (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .start_i (clr_start),
    .gnt_i   (clr_gnt),
    .mem_o   (clr_mem),
    .done_o  (clr_done)
  );

  chain_insert_engine u_insert (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .start_i       (ins_start),
    .reset_alloc_i (reset_alloc),
    .key_i         (key),
    .value_i       (value),
    .head_ptr_i    (head_ptr),
    .head_val_i    (head_val),
    .gnt_i         (ins_gnt),
    .mem_o         (ins_mem),
    .done_o        (ins_done),
    .status_o      (ins_status),
    .new_addr_o    (ins_addr)
  );

  chain_search_engine u_search (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .start_i    (srch_start),
    .key_i      (key),
    .head_ptr_i (head_ptr),
    .head_val_i (head_val),
    .gnt_i      (srch_gnt),
    .rd_data_i  (ram_rdata),
    .mem_o      (srch_mem),
    .done_o     (srch_done),
    .found_o    (srch_found),
    .value_o    (srch_value)
  );

  entry_ram_arbiter u_arbiter (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .clr_req_i   (clr_mem),
    .ins_req_i   (ins_mem),
    .srch_req_i  (srch_mem),
    .clr_gnt_o   (clr_gnt),
    .ins_gnt_o   (ins_gnt),
    .srch_gnt_o  (srch_gnt),
    .ram_en_o    (ram_en),
    .ram_we_o    (ram_we),
    .ram_addr_o  (ram_addr),
    .ram_wdata_o (ram_wdata)
  );

  entry_ram u_ram (
    .clk_i   (clk_i),
    .en_i    (ram_en),
    .we_i    (ram_we),
    .addr_i  (ram_addr),
    .wdata_i (ram_wdata),
    .rdata_o (ram_rdata)
  );

endmodule

//--- tests/hash_table_asserts.sv
`timescale 1ns/100ps

module hash_table_asserts (
  input logic                    clk_i,
  input logic                    rst_i,
  input logic                    cmd_req_i,
  input logic                    cmd_ack_i,
  input hash_table_pkg::ht_res_t res_i,
  input logic                    clr_gnt_i,
  input logic                    ins_gnt_i,
  input logic                    srch_gnt_i
);

  // an acknowledge only ever answers a live request
  ack_needs_req: assert property (@(posedge clk_i) disable iff (rst_i)
    $rose(cmd_ack_i) |-> cmd_req_i)
  else
    $error("cmd_ack_o rose while cmd_req_i was low");

  // ack held as long as the host holds the request
  ack_held: assert property (@(posedge clk_i) disable iff (rst_i)
    (cmd_ack_i && cmd_req_i) |=> cmd_ack_i)
  else
    $error("cmd_ack_o fell while cmd_req_i was still high");

  // result frozen for the whole acknowledge
  res_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    cmd_ack_i |=> (!cmd_ack_i || $stable(res_i)))
  else
    $error("res_o changed while cmd_ack_o was high");

  // single-port RAM, one master per cycle
  one_grant: assert property (@(posedge clk_i) disable iff (rst_i)
    $onehot0({clr_gnt_i, ins_gnt_i, srch_gnt_i}))
  else
    $error("more than one RAM grant in a cycle");

endmodule

bind hash_table_top hash_table_asserts u_asserts (
  .clk_i      (clk_i),
  .rst_i      (rst_i),
  .cmd_req_i  (cmd_req_i),
  .cmd_ack_i  (cmd_ack_o),
  .res_i      (res_o),
  .clr_gnt_i  (clr_gnt),
  .ins_gnt_i  (ins_gnt),
  .srch_gnt_i (srch_gnt)
);

//--- tests/hash_table_tb.sv
`timescale 1ns/100ps

`include "hash_table_params.svh"

module hash_table_tb;

  localparam int KW          = `HT_KEY_WIDTH;
  localparam int BW          = `HT_BUCKET_WIDTH;
  localparam int NUM_ENTRIES = 2**`HT_ADDR_WIDTH;
  // about 112 commands of at most 33 cycles each including handshake and hold
  localparam int MAX_COMMANDS = 120;
  localparam int CMD_CYCLES   = 33;
  localparam int MAX_CYCLES   = MAX_COMMANDS * CMD_CYCLES + 40;

  logic                    clk;
  logic                    rst;
  logic                    cmd_req;
  hash_table_pkg::ht_cmd_t cmd;
  logic                    cmd_ack;
  hash_table_pkg::ht_res_t res;

  int seed;
  int cycle_count;

  // reference table holding entries in insert order since the last clear
  logic [`HT_KEY_WIDTH-1:0]   ref_keys [NUM_ENTRIES];
  logic [`HT_VALUE_WIDTH-1:0] ref_vals [NUM_ENTRIES];
  int                         ref_count;

  // one expected result per issued command
  hash_table_pkg::ht_res_t expect_q [$];
  hash_table_pkg::ht_res_t exp_res;
  hash_table_pkg::ht_res_t held_res;
  logic                    ack_seen;

  // keys of the filled table that are searched again after the clear
  logic [`HT_KEY_WIDTH-1:0] saved_keys [NUM_ENTRIES];

  hash_table_top u_dut (
    .clk_i     (clk),
    .rst_i     (rst),
    .cmd_req_i (cmd_req),
    .cmd_i     (cmd),
    .cmd_ack_o (cmd_ack),
    .res_o     (res)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic abort_run();
    $display("RESULT: FAIL");
    $fatal(1, "simulation stopped at the first failure");
  endtask

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected)
    begin
      $display("** Error at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
      abort_run();
    end
  endtask

  function automatic logic [KW-1:0] random_word();
    int r;
    r = $random(seed);
    return r[KW-1:0];
  endfunction

  // full 3-bit slices xored together with leftover top bits folded onto the low end
  function automatic logic [BW-1:0] bucket_of(input logic [KW-1:0] key);
    logic [BW-1:0] b;
    logic [BW-1:0] rest;
    b    = '0;
    rest = '0;
    for (int s = 0; s + BW <= KW; s += BW)
      b ^= key[s +: BW];
    for (int i = (KW / BW) * BW; i < KW; i++)
      rest[i - (KW / BW) * BW] = key[i];
    return b ^ rest;
  endfunction

  // random key forced into the bucket of base
  function automatic logic [KW-1:0] bucket_partner(input logic [KW-1:0] base);
    logic [KW-1:0] k;
    k = random_word();
    // the low slice shifts the bucket bit for bit
    k[BW-1:0] = k[BW-1:0] ^ bucket_of(k) ^ bucket_of(base);
    // bits 0 and 3 cancel in the fold
    if (k == base)
      k = k ^ 16'h0009;
    return k;
  endfunction

  // expected result of one command and model update as a side effect
  function automatic hash_table_pkg::ht_res_t model_command(input hash_table_pkg::ht_cmd_t c);
    hash_table_pkg::ht_res_t r;
    logic                    hit;
    r.status = hash_table_pkg::ST_CLEARED;
    r.value  = '0;
    hit      = 1'b0;
    case (c.opcode)
      hash_table_pkg::OP_INSERT:
      begin
        if (ref_count == NUM_ENTRIES)
          r.status = hash_table_pkg::ST_TABLE_FULL;
        else
        begin
          ref_keys[ref_count] = c.key;
          ref_vals[ref_count] = c.value;
          ref_count++;
          r.status = hash_table_pkg::ST_INSERTED;
        end
      end
      hash_table_pkg::OP_SEARCH:
      begin
        r.status = hash_table_pkg::ST_NOT_FOUND;
        // newest entry first so a repeated key gives its latest value
        for (int i = NUM_ENTRIES - 1; i >= 0; i--)
        begin
          if (!hit && i < ref_count && ref_keys[i] == c.key)
          begin
            hit      = 1'b1;
            r.status = hash_table_pkg::ST_FOUND;
            r.value  = ref_vals[i];
          end
        end
      end
      default:
        ref_count = 0;
    endcase
    return r;
  endfunction

  // four-phase host transfer with the request held for hold extra cycles after the ack
  task automatic run_command(input hash_table_pkg::ht_cmd_t c, input int hold);
    expect_q.push_back(model_command(c));
    @(posedge clk);
    cmd_req <= 1'b1;
    cmd     <= c;
    wait (cmd_ack === 1'b1);
    repeat (hold) @(posedge clk);
    @(posedge clk);
    cmd_req <= 1'b0;
    wait (cmd_ack === 1'b0);
  endtask

  task automatic issue_insert(input logic [KW-1:0] key,
                              input logic [`HT_VALUE_WIDTH-1:0] value,
                              input int hold);
    hash_table_pkg::ht_cmd_t c;
    c.opcode = hash_table_pkg::OP_INSERT;
    c.key    = key;
    c.value  = value;
    run_command(c, hold);
  endtask

  task automatic issue_search(input logic [KW-1:0] key, input int hold);
    hash_table_pkg::ht_cmd_t c;
    c.opcode = hash_table_pkg::OP_SEARCH;
    c.key    = key;
    c.value  = '0;
    run_command(c, hold);
  endtask

  task automatic issue_clear(input int hold);
    hash_table_pkg::ht_cmd_t c;
    c.opcode = hash_table_pkg::OP_CLEAR;
    c.key    = '0;
    c.value  = '0;
    run_command(c, hold);
  endtask

  // compare on the first sampled ack cycle and then watch res stay put
  always @(posedge clk)
  begin
    if (rst)
      ack_seen <= 1'b0;
    else
    begin
      if (cmd_ack && !ack_seen)
      begin
        check_value(expect_q.size(), 1, "pending commands at acknowledge");
        exp_res = expect_q.pop_front();
        check_value(res.status, exp_res.status, "result status");
        if (exp_res.status == hash_table_pkg::ST_FOUND)
          check_value(res.value, exp_res.value, "search value");
        held_res = res;
      end
      else if (cmd_ack && ack_seen)
        check_value(res, held_res, "result held during acknowledge");
      ack_seen <= cmd_ack;
    end
  end

  initial
  begin
    cycle_count = 0;
    forever
    begin
      @(posedge clk);
      cycle_count++;
      if (cycle_count >= MAX_CYCLES)
      begin
        $display("timeout: no end of test after %0d clock cycles", cycle_count);
        abort_run();
      end
    end
  end

  initial
  begin
    logic [KW-1:0] base_keys [4];
    logic [KW-1:0] pair_keys [4];
    logic [KW-1:0] key;
    int            hold;
    seed        = 90045;
    ref_count   = 0;
    rst         = 1'b1;
    cmd_req     = 1'b0;
    cmd         = '0;
    repeat (3) @(posedge clk);
    rst <= 1'b0;

    // empty table after reset
    issue_clear(0);
    for (int i = 0; i < 4; i++)
      issue_search(random_word(), 0);

    // random keys with a partner in the same bucket for each
    issue_clear(0);
    for (int i = 0; i < 4; i++)
    begin
      base_keys[i] = random_word();
      pair_keys[i] = bucket_partner(base_keys[i]);
      issue_insert(base_keys[i], random_word(), 0);
      issue_insert(pair_keys[i], random_word(), 0);
    end
    for (int i = 0; i < 4; i++)
    begin
      issue_search(base_keys[i], 0);
      issue_search(pair_keys[i], 0);
    end
    // misses with one of them walking a populated chain
    issue_search(bucket_partner(base_keys[0]), 0);
    issue_search(random_word(), 0);

    // same key twice where the newer value wins
    issue_clear(0);
    key = random_word();
    issue_insert(key, random_word(), 0);
    issue_insert(key, random_word(), 0);
    issue_search(key, 0);

    // fill all entries and then have one more insert refused
    issue_clear(0);
    for (int i = 0; i < NUM_ENTRIES; i++)
    begin
      saved_keys[i] = random_word();
      issue_insert(saved_keys[i], random_word(), 0);
    end
    issue_insert(random_word(), random_word(), 0);
    for (int i = 0; i < NUM_ENTRIES; i++)
      issue_search(saved_keys[i], 0);

    // clear a full table and refill it
    issue_clear(0);
    for (int i = 0; i < NUM_ENTRIES; i++)
      issue_search(saved_keys[i], 0);
    for (int i = 0; i < NUM_ENTRIES; i++)
    begin
      saved_keys[i] = random_word();
      issue_insert(saved_keys[i], random_word(), 0);
    end
    for (int i = 0; i < NUM_ENTRIES; i += 2)
      issue_search(saved_keys[i], 0);

    // host keeps the request up for random cycles after each ack
    issue_clear(1 + random_word() % 6);
    for (int i = 0; i < 4; i++)
    begin
      hold = 1 + random_word() % 6;
      key  = random_word();
      issue_insert(key, random_word(), hold);
      hold = 1 + random_word() % 6;
      issue_search(key, hold);
    end

    $display("RESULT: PASS");
    $finish;
  end

endmodule

//--- list.f
+incdir+include
hdl/hash_table_pkg.sv
hdl/entry_ram.sv
hdl/entry_ram_arbiter.sv
hdl/table_clear_engine.sv
hdl/chain_insert_engine.sv
hdl/chain_search_engine.sv
hdl/hash_cmd_ctrl.sv
hdl/hash_table_top.sv
tests/hash_table_asserts.sv
tests/hash_table_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= hash_table_tb
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps -Wno-fatal

BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	-$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "RESULT: PASS" $(LOG); then echo "simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
